/* mem_wb_top.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/data_memory.sv
rtl/mem_wb_stage.sv
rtl/write_back_regfile.sv
rtl/mem_wb_top.sv
sim/mem_wb_props.sv
sim/mem_wb_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := mem_wb_tb
FILELIST := mem_wb_top.f
OBJ_DIR  := obj_dir
PASS_MSG := All tests passed!

.PHONY: sim clean

# build, run and grep the output for the pass line
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/mem_wb_stim.txt */
# I en op sel alu store pc rd we  (op 0 none 1 lw 2 lb 3 sw 4 sb; sel 0 alu 1 mem 2 pc)
# W we rd data | R addr_a exp_a addr_b exp_b | X addr rd (random word) ; all hex
R 1 00000000 1f 00000000
I 1 1 1 00000008 00000000 0 1 1
W 1 1 00000000
# alu write-back
I 1 0 0 12345678 00000000 0 1 1
W 1 1 12345678
R 1 12345678 0 00000000
I 1 0 0 deadbeef 00000000 0 2 1
W 1 2 deadbeef
R 2 deadbeef 1 12345678
# word store then load
I 1 3 0 00000010 cafef00d 0 0 0
I 1 1 1 00000010 00000000 0 3 1
W 1 3 cafef00d
R 3 cafef00d 2 deadbeef
# no memory op gives zero load data
I 1 0 1 00000010 00000000 0 f 1
W 1 f 00000000
# byte store into lane 2, signed byte load, word load
I 1 3 0 00000020 11223344 0 0 0
I 1 4 0 00000022 000000a5 0 0 0
I 1 2 1 00000022 00000000 0 4 1
W 1 4 ffffffa5
I 1 1 1 00000020 00000000 0 5 1
W 1 5 11a53344
R 4 ffffffa5 5 11a53344
# lane 1 with a positive byte, upper store bits ignored
I 1 4 0 00000021 abcdef7f 0 0 0
I 1 2 1 00000021 00000000 0 6 1
W 1 6 0000007f
I 1 1 1 00000020 00000000 0 7 1
W 1 7 11a57f44
R 6 0000007f 7 11a57f44
I 1 2 1 00000023 00000000 0 8 1
W 1 8 00000011
# link pc
I 1 0 2 00000044 00000000 5a 9 1
W 1 9 0000005a
R 9 0000005a 0 00000000
# stall holds the bus and blocks stores
I 1 0 0 a5a5a5a5 00000000 0 a 1
W 1 a a5a5a5a5
I 0 3 0 00000010 99999999 0 b 1
W 1 a a5a5a5a5
I 0 4 0 00000011 000000ee 0 b 1
W 1 a a5a5a5a5
I 1 1 1 00000010 00000000 0 b 1
W 1 b cafef00d
R a a5a5a5a5 b cafef00d
# r0 and write flag
I 1 0 0 ffffffff 00000000 0 0 1
W 1 0 ffffffff
R 0 00000000 1 12345678
I 1 0 0 0badf00d 00000000 0 1 0
W 0 1 0badf00d
R 1 12345678 0 00000000
# random words
X 00000030 c
X 000000fc d
X 00000004 e

/* sim/mem_wb_tb.sv */
`timescale 1ns/1ns

`include "cpu_macros.svh"

module mem_wb_tb
	import cpu_pkg::*;
;

	localparam string STIM_FILE   = "sim/mem_wb_stim.txt";
	localparam int    BUS_TIMEOUT = 8;
	localparam int    WORD_MSB    = $clog2(`DMEM_WORDS) + 1;

	logic                clock_i;
	logic                reset_i;
	logic                enable_pipe_i;
	logic [`NB_DATA-1:0] alu_result_i;
	logic [`NB_DATA-1:0] store_data_i;
	logic [`NB_PC-1:0]   pc_i;
	logic [`NB_REG-1:0]  write_register_i;
	logic                reg_write_i;
	wb_sel_e             wb_sel_i;
	mem_op_e             mem_op_i;
	logic [`NB_REG-1:0]  read_addr_a_i;
	logic [`NB_REG-1:0]  read_addr_b_i;
	logic [`NB_DATA-1:0] read_data_a_o;
	logic [`NB_DATA-1:0] read_data_b_o;
	logic                reg_write_o;
	logic [`NB_REG-1:0]  write_register_o;
	logic [`NB_DATA-1:0] write_data_o;

	int num_checks;
	int check_errors;
	int timeout_errors;
	int other_errors;

	logic [31:0]         lfsr_state;
	// reference contents for the random store/load lines
	logic [`NB_DATA-1:0] model_reg [0:31];
	logic [`NB_DATA-1:0] model_mem [0:`DMEM_WORDS-1];

	mem_wb_top DUT (.*);

	initial
	begin
		clock_i = 1'b0;
		forever #4 clock_i = ~clock_i;
	end

	// galois form, taps for a maximal 32-bit sequence
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic random_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		num_checks++;
		if (got !== exp)
		begin
			check_errors++;
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// idle slot: accepted, but writes nothing anywhere
	task automatic drive_bubble();
		enable_pipe_i    = 1'b1;
		mem_op_i         = MEM_NONE;
		wb_sel_i         = WB_ALU;
		alu_result_i     = '0;
		store_data_i     = '0;
		pc_i             = '0;
		write_register_i = '0;
		reg_write_i      = 1'b0;
	endtask

	task automatic issue_instr(input logic en, input mem_op_e op, input wb_sel_e sel,
		input logic [31:0] alu, input logic [31:0] store, input logic [6:0] pc,
		input logic [4:0] rd, input logic we);
		enable_pipe_i    = en;
		mem_op_i         = op;
		wb_sel_i         = sel;
		alu_result_i     = alu;
		store_data_i     = store;
		pc_i             = pc;
		write_register_i = rd;
		reg_write_i      = we;
		@(posedge clock_i);
		#1;
		drive_bubble();
	endtask

	task automatic check_bus(input logic we, input logic [4:0] rd, input logic [31:0] data);
		bit found;
		found = 1'b0;
		for (int i = 0; i < BUS_TIMEOUT; i++)
		begin
			if (reg_write_o === we && write_register_o === rd)
			begin
				found = 1'b1;
				break;
			end
			@(posedge clock_i);
			#1;
		end
		if (!found)
		begin
			timeout_errors++;
			$display("ERROR at %0t ns: write-back of register %0d never showed up", $time, rd);
		end
		else
		begin
			check_value(write_data_o, data, $sformatf("write-back data for r%0d", rd));
		end
	endtask

	// one more edge so the write-back lands in the register file
	task automatic check_reads(input logic [4:0] addr_a, input logic [31:0] exp_a,
		input logic [4:0] addr_b, input logic [31:0] exp_b);
		@(posedge clock_i);
		#1;
		read_addr_a_i = addr_a;
		read_addr_b_i = addr_b;
		#1;
		check_value(read_data_a_o, exp_a, $sformatf("read port a, r%0d", addr_a));
		check_value(read_data_b_o, exp_b, $sformatf("read port b, r%0d", addr_b));
	endtask

	task automatic store_load_random(input logic [31:0] addr, input logic [4:0] rd);
		logic [31:0] data;
		random_word(data);
		issue_instr(1'b1, MEM_SW, WB_ALU, addr, data, '0, '0, 1'b0);
		model_mem[addr[WORD_MSB:2]] = data;
		issue_instr(1'b1, MEM_LW, WB_MEM, addr, '0, '0, rd, 1'b1);
		model_reg[rd] = model_mem[addr[WORD_MSB:2]];
		check_bus(1'b1, rd, model_reg[rd]);
		check_reads(rd, model_reg[rd], 5'd0, 32'd0);
	endtask

	task automatic run_stimulus();
		int          fd;
		int          code;
		int          n;
		string       line;
		string       rest;
		byte         tag;
		logic [31:0] f [0:7];
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			other_errors++;
			$display("ERROR: could not open stimulus file %s", STIM_FILE);
			return;
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code > 0)
			begin
				tag  = line[0];
				rest = line.substr(1, line.len() - 1);
				case (tag)
					"I":
					begin
						n = $sscanf(rest, "%h %h %h %h %h %h %h %h",
							f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
						if (n == 8)
						begin
							issue_instr(f[0][0], mem_op_e'(f[1][2:0]), wb_sel_e'(f[2][1:0]),
								f[3], f[4], f[5][6:0], f[6][4:0], f[7][0]);
						end
						else
						begin
							other_errors++;
							$display("ERROR: malformed instruction line: %s", line);
						end
					end
					"W":
					begin
						n = $sscanf(rest, "%h %h %h", f[0], f[1], f[2]);
						if (n == 3)
						begin
							check_bus(f[0][0], f[1][4:0], f[2]);
						end
						else
						begin
							other_errors++;
							$display("ERROR: malformed bus check line: %s", line);
						end
					end
					"R":
					begin
						n = $sscanf(rest, "%h %h %h %h", f[0], f[1], f[2], f[3]);
						if (n == 4)
						begin
							check_reads(f[0][4:0], f[1], f[2][4:0], f[3]);
						end
						else
						begin
							other_errors++;
							$display("ERROR: malformed read check line: %s", line);
						end
					end
					"X":
					begin
						n = $sscanf(rest, "%h %h", f[0], f[1]);
						if (n == 2)
						begin
							store_load_random(f[0], f[1][4:0]);
						end
						else
						begin
							other_errors++;
							$display("ERROR: malformed random line: %s", line);
						end
					end
					"#", 8'h0a, 8'h0d, 8'h20:
					begin
						// comment or blank line
					end
					default:
					begin
						other_errors++;
						$display("ERROR: unknown stimulus line: %s", line);
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	initial
	begin
		reset_i          = 1'b1;
		enable_pipe_i    = 1'b0;
		mem_op_i         = MEM_NONE;
		wb_sel_i         = WB_ALU;
		alu_result_i     = '0;
		store_data_i     = '0;
		pc_i             = '0;
		write_register_i = '0;
		reg_write_i      = 1'b0;
		read_addr_a_i    = '0;
		read_addr_b_i    = '0;
		num_checks       = 0;
		check_errors     = 0;
		timeout_errors   = 0;
		other_errors     = 0;
		lfsr_state       = 32'hea18;
		for (int i = 0; i < 32; i++)
		begin
			model_reg[i] = '0;
		end
		for (int i = 0; i < `DMEM_WORDS; i++)
		begin
			model_mem[i] = '0;
		end

		repeat (5) @(posedge clock_i);
		#1;
		reset_i = 1'b0;
		drive_bubble();

		run_stimulus();

		$display("checks: %0d, check errors: %0d, timeouts: %0d, other errors: %0d",
			num_checks, check_errors, timeout_errors, other_errors);
		if (check_errors + timeout_errors + other_errors == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* sim/mem_wb_props.sv */
`timescale 1ns/1ns

`include "cpu_macros.svh"

module mem_wb_props
(
	input logic                clock_i,
	input logic                reset_i,
	input logic                enable_pipe_i,
	input logic                wb_reg_write_i,
	input logic [`NB_REG-1:0]  wb_register_i,
	input logic [`NB_DATA-1:0] wb_data_i,
	input logic [`NB_REG-1:0]  rd_addr_a_i,
	input logic [`NB_DATA-1:0] rd_data_a_i
);

	// write-back bus comes out of reset with no write pending
	assert property (@(posedge clock_i) $fell(reset_i) |-> !wb_reg_write_i)
		else $error("reg_write_o is set right after reset");

	// stalled stage keeps the whole write-back bus
	assert property (@(posedge clock_i) disable iff (reset_i)
		!enable_pipe_i |=> $stable(wb_reg_write_i) && $stable(wb_register_i)
			&& $stable(wb_data_i))
		else $error("write-back bus changed during a stall");

	// r0 holds zero from reset on
	assert property (@(posedge clock_i) disable iff (reset_i)
		(rd_addr_a_i == '0) |-> (rd_data_a_i == '0))
		else $error("read port a returned nonzero data for register 0");

endmodule

bind mem_wb_top mem_wb_props u_mem_wb_props (
	.clock_i        (clock_i),
	.reset_i        (reset_i),
	.enable_pipe_i  (enable_pipe_i),
	.wb_reg_write_i (reg_write_o),
	.wb_register_i  (write_register_o),
	.wb_data_i      (write_data_o),
	.rd_addr_a_i    (read_addr_a_i),
	.rd_data_a_i    (read_data_a_o)
);

/* rtl/mem_wb_top.sv */
`timescale 1ns/1ns

`include "cpu_macros.svh"

module mem_wb_top
	import cpu_pkg::*;
(
	input  logic                clock_i,
	input  logic                reset_i,
	input  logic                enable_pipe_i,
	input  logic [`NB_DATA-1:0] alu_result_i,
	input  logic [`NB_DATA-1:0] store_data_i,
	input  logic [`NB_PC-1:0]   pc_i,
	input  logic [`NB_REG-1:0]  write_register_i,
	input  logic                reg_write_i,
	input  wb_sel_e             wb_sel_i,
	input  mem_op_e             mem_op_i,
	input  logic [`NB_REG-1:0]  read_addr_a_i,
	input  logic [`NB_REG-1:0]  read_addr_b_i,
	output logic [`NB_DATA-1:0] read_data_a_o,
	output logic [`NB_DATA-1:0] read_data_b_o,
	output logic                reg_write_o,
	output logic [`NB_REG-1:0]  write_register_o,
	output logic [`NB_DATA-1:0] write_data_o
);

	logic [`NB_DATA-1:0] load_data;
	logic [`NB_DATA-1:0] wb_mem_data;
	logic [`NB_DATA-1:0] wb_alu_result;
	logic [`NB_PC-1:0]   wb_pc;
	wb_sel_e             wb_sel;

	// memory access, alu result is the data address
	data_memory u_data_memory (
		.clock_i       (clock_i),
		.reset_i       (reset_i),
		.enable_pipe_i (enable_pipe_i),
		.mem_op_i      (mem_op_i),
		.addr_i        (alu_result_i),
		.store_data_i  (store_data_i),
		.load_data_o   (load_data)
	);

	mem_wb_stage u_mem_wb_stage (
		.clock_i          (clock_i),
		.reset_i          (reset_i),
		.enable_pipe_i    (enable_pipe_i),
		.mem_data_read_i  (load_data),
		.alu_result_i     (alu_result_i),
		.pc_i             (pc_i),
		.write_register_i (write_register_i),
		.reg_write_i      (reg_write_i),
		.wb_sel_i         (wb_sel_i),
		.mem_data_read_o  (wb_mem_data),
		.alu_result_o     (wb_alu_result),
		.pc_o             (wb_pc),
		.write_register_o (write_register_o),
		.reg_write_o      (reg_write_o),
		.wb_sel_o         (wb_sel)
	);

	// registered stage outputs feed the write-back bus
	write_back_regfile u_write_back_regfile (
		.clock_i          (clock_i),
		.reset_i          (reset_i),
		.reg_write_i      (reg_write_o),
		.write_register_i (write_register_o),
		.wb_sel_i         (wb_sel),
		.mem_data_i       (wb_mem_data),
		.alu_result_i     (wb_alu_result),
		.pc_i             (wb_pc),
		.read_addr_a_i    (read_addr_a_i),
		.read_addr_b_i    (read_addr_b_i),
		.read_data_a_o    (read_data_a_o),
		.read_data_b_o    (read_data_b_o),
		.write_data_o     (write_data_o)
	);

endmodule

/* rtl/write_back_regfile.sv */
`timescale 1ns/1ns

`include "cpu_macros.svh"

module write_back_regfile
	import cpu_pkg::*;
(
	input  logic                clock_i,
	input  logic                reset_i,
	input  logic                reg_write_i,
	input  logic [`NB_REG-1:0]  write_register_i,
	input  wb_sel_e             wb_sel_i,
	input  logic [`NB_DATA-1:0] mem_data_i,
	input  logic [`NB_DATA-1:0] alu_result_i,
	input  logic [`NB_PC-1:0]   pc_i,
	input  logic [`NB_REG-1:0]  read_addr_a_i,
	input  logic [`NB_REG-1:0]  read_addr_b_i,
	output logic [`NB_DATA-1:0] read_data_a_o,
	output logic [`NB_DATA-1:0] read_data_b_o,
	output logic [`NB_DATA-1:0] write_data_o
);

	localparam int NUM_REGS = 1 << `NB_REG;

	logic [`NB_DATA-1:0] regs [0:NUM_REGS-1];

	// write-back source mux
	always_comb
	begin
		case (wb_sel_i)
			WB_ALU:  write_data_o = alu_result_i;
			WB_MEM:  write_data_o = mem_data_i;
			WB_PC:   write_data_o = {{(`NB_DATA-`NB_PC){1'b0}}, pc_i};
			default: write_data_o = '0;
		endcase
	end

	// r0 is never written and keeps its reset value of zero
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (reg_write_i && (write_register_i != '0))
		begin
			regs[write_register_i] <= write_data_o;
		end
	end

	// asynchronous read ports without bypass from the write-back bus
	always_comb
	begin
		read_data_a_o = regs[read_addr_a_i];
		read_data_b_o = regs[read_addr_b_i];
	end

endmodule

/* rtl/mem_wb_stage.sv */
`timescale 1ns/1ns

`include "cpu_macros.svh"

module mem_wb_stage
	import cpu_pkg::*;
(
	input  logic                clock_i,
	input  logic                reset_i,
	input  logic                enable_pipe_i,

	input  logic [`NB_DATA-1:0] mem_data_read_i,
	input  logic [`NB_DATA-1:0] alu_result_i,
	input  logic [`NB_PC-1:0]   pc_i,
	input  logic [`NB_REG-1:0]  write_register_i,
	input  logic                reg_write_i,
	input  wb_sel_e             wb_sel_i,

	output logic [`NB_DATA-1:0] mem_data_read_o,
	output logic [`NB_DATA-1:0] alu_result_o,
	output logic [`NB_PC-1:0]   pc_o,
	output logic [`NB_REG-1:0]  write_register_o,
	output logic                reg_write_o,
	output wb_sel_e             wb_sel_o
);

	// everything clears on reset so the write-back bus starts quiet
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			mem_data_read_o  <= '0;
			alu_result_o     <= '0;
			pc_o             <= '0;
			write_register_o <= '0;
			reg_write_o      <= 1'b0;
			wb_sel_o         <= WB_ALU;
		end
		else if (enable_pipe_i)
		begin
			mem_data_read_o  <= mem_data_read_i;
			alu_result_o     <= alu_result_i;
			pc_o             <= pc_i;
			write_register_o <= write_register_i;
			reg_write_o      <= reg_write_i;
			wb_sel_o         <= wb_sel_i;
		end
		// stalled: hold the current contents
		else
		begin
			mem_data_read_o  <= mem_data_read_o;
			alu_result_o     <= alu_result_o;
			pc_o             <= pc_o;
			write_register_o <= write_register_o;
			reg_write_o      <= reg_write_o;
			wb_sel_o         <= wb_sel_o;
		end
	end

endmodule

/* rtl/data_memory.sv */
`timescale 1ns/1ns

`include "cpu_macros.svh"

module data_memory
	import cpu_pkg::*;
(
	input  logic                clock_i,
	input  logic                reset_i,
	input  logic                enable_pipe_i,
	input  mem_op_e             mem_op_i,
	input  logic [`NB_DATA-1:0] addr_i,
	input  logic [`NB_DATA-1:0] store_data_i,
	output logic [`NB_DATA-1:0] load_data_o
);

	localparam int ADDR_W = $clog2(`DMEM_WORDS);

	logic [`NB_DATA-1:0] mem [0:`DMEM_WORDS-1];
	logic [ADDR_W-1:0]   word_idx;
	logic [1:0]          lane;
	logic [`NB_DATA-1:0] word_rd;
	logic [7:0]          byte_rd;

	// word index sits just above the byte offset
	assign word_idx = addr_i[ADDR_W+1:2];
	assign lane     = addr_i[1:0];
	assign word_rd  = mem[word_idx];

	// stores only land when the pipe accepts the instruction
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < `DMEM_WORDS; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (enable_pipe_i && is_store(mem_op_i))
		begin
			if (mem_op_i == MEM_SW)
			begin
				mem[word_idx] <= store_data_i;
			end
			else
			begin
				// low byte of store data into the addressed lane
				mem[word_idx][8*lane +: 8] <= store_data_i[7:0];
			end
		end
	end

	// pick the addressed byte lane
	always_comb
	begin
		case (lane)
			2'd0:    byte_rd = word_rd[7:0];
			2'd1:    byte_rd = word_rd[15:8];
			2'd2:    byte_rd = word_rd[23:16];
			default: byte_rd = word_rd[31:24];
		endcase
	end

	// asynchronous load path, zero when not loading
	always_comb
	begin
		case (mem_op_i)
			MEM_LW:
			begin
				load_data_o = word_rd;
			end
			MEM_LB:
			begin
				load_data_o = {{(`NB_DATA-8){byte_rd[7]}}, byte_rd};
			end
			default:
			begin
				load_data_o = '0;
			end
		endcase
	end

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

	// write-back source select, same encoding as the mem_to_reg field
	typedef enum logic [1:0]
	{
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_PC  = 2'd2
	} wb_sel_e;

	// memory access opcode carried with the instruction
	typedef enum logic [2:0]
	{
		MEM_NONE = 3'd0,
		MEM_LW   = 3'd1,
		MEM_LB   = 3'd2,
		MEM_SW   = 3'd3,
		MEM_SB   = 3'd4
	} mem_op_e;

	// true when the opcode writes the data memory
	function automatic logic is_store(input mem_op_e op);
		return (op == MEM_SW) || (op == MEM_SB);
	endfunction

endpackage

/* rtl/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path word width
`define NB_DATA 32

// register file index width
`define NB_REG 5

// link pc width carried down the pipe
`define NB_PC 7

// data memory depth in words
`define DMEM_WORDS 64

`endif
